//--- logic/front_end_pkg.sv
package front_end_pkg;

    // one data or address word
    typedef logic [31:0] word_t;

    // coarse instruction class seen by the issue stage
    typedef enum logic [2:0] {
        cls_alu_r,
        cls_alu_i,
        cls_branch,
        cls_jump,
        cls_jump_reg,
        cls_load,
        cls_store
    } instr_class_t;

    // class from the major opcode, funct only matters for special
    function automatic instr_class_t classify(word_t instr);
        logic [5:0] op;
        logic [5:0] funct;
        instr_class_t cls;
        op = instr[31:26];
        funct = instr[5:0];
        if (op == 6'b000000)
        begin
            // jr lives under special
            cls = (funct == 6'b001000) ? cls_jump_reg : cls_alu_r;
        end
        else if (op == 6'b000010 || op == 6'b000011)
            cls = cls_jump;
        else if (op[5:2] == 4'b0001)
            cls = cls_branch;
        else if (op[5:3] == 3'b100)
            cls = cls_load;
        else if (op[5:3] == 3'b101)
            cls = cls_store;
        else
            cls = cls_alu_i;
        return cls;
    endfunction

    // j / jal target, region bits come from pc + 4
    function automatic word_t jump_target(word_t pc, word_t instr);
        word_t pc_plus4;
        pc_plus4 = pc + 32'd4;
        return {pc_plus4[31:28], instr[25:0], 2'b00};
    endfunction

endpackage

//--- logic/fetch_unit.sv
module fetch_unit #(
    parameter int QUEUE_DEPTH = 8,
    parameter front_end_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                 clk,
    input  logic                 reset,
    // commit side redirect
    input  logic                 redirect,
    input  front_end_pkg::word_t redirect_pc,
    // jump found by the predecoder
    input  logic                 jump_redirect,
    input  front_end_pkg::word_t jump_target,
    // instruction bus
    output logic                 ibus_req,
    output front_end_pkg::word_t ibus_addr,
    input  logic                 ibus_resp,
    input  logic [63:0]          ibus_data,
    // into the queue
    output logic [1:0]           push_valid,
    output front_end_pkg::word_t push_pc0,
    output front_end_pkg::word_t push_pc1,
    output front_end_pkg::word_t push_instr0,
    output front_end_pkg::word_t push_instr1,
    input  logic [1:0]           credit_return
);
    import front_end_pkg::*;

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_waiting,
        st_draining
    } fetch_state_t;

    fetch_state_t state;
    word_t pc;
    word_t pc_next;
    word_t new_pc;
    logic [CW-1:0] credits;
    logic [CW-1:0] credits_next;
    logic [1:0] push_count;
    logic any_redirect;
    logic accept;
    logic odd_word;

    assign any_redirect = redirect | jump_redirect;
    // commit wins over the predecoder jump
    assign new_pc = redirect ? redirect_pc : jump_target;

    assign odd_word = pc[2];
    assign accept = (state == st_waiting) && ibus_resp;

    // the pair is fetched as one aligned doubleword
    assign ibus_addr = {pc[31:3], 1'b0, pc[1:0]};

    // hold off while a redirect is being taken, the new pc goes out next cycle
    assign ibus_req = (state == st_idle) && (credits >= CW'(2)) && !any_redirect;

    // response alignment
    always_comb
    begin
        push_valid = 2'b00;
        push_pc0 = pc;
        push_pc1 = pc + 32'd4;
        // only the odd word is wanted for an odd pc
        push_instr0 = odd_word ? ibus_data[63:32] : ibus_data[31:0];
        push_instr1 = ibus_data[63:32];
        // a response that meets a redirect belongs to the old path
        if (accept && !any_redirect)
            push_valid = odd_word ? 2'b01 : 2'b11;
    end

    assign push_count = {1'b0, push_valid[1]} + {1'b0, push_valid[0]};
    assign pc_next = pc + (odd_word ? 32'd4 : 32'd8);
    assign credits_next = credits + CW'(credit_return) - CW'(push_count);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= st_idle;
            pc <= RESET_PC;
            credits <= CW'(QUEUE_DEPTH);
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (ibus_req)
                        state <= st_waiting;
                end
                st_waiting:
                begin
                    if (ibus_resp)
                        state <= st_idle;
                    else if (any_redirect)
                        state <= st_draining;
                end
                st_draining:
                begin
                    // stale response, thrown away
                    if (ibus_resp)
                        state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase

            if (any_redirect)
            begin
                // queue is flushed in the same cycle, in-flight returns are dropped
                pc <= new_pc;
                credits <= CW'(QUEUE_DEPTH);
            end
            else
            begin
                if (accept)
                    pc <= pc_next;
                credits <= credits_next;
            end
        end
    end

endmodule

//--- logic/instr_queue.sv
module instr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    // from fetch
    input  logic [1:0]           push_valid,
    input  front_end_pkg::word_t push_pc0,
    input  front_end_pkg::word_t push_pc1,
    input  front_end_pkg::word_t push_instr0,
    input  front_end_pkg::word_t push_instr1,
    // to the predecoder
    output logic [1:0]           head_valid,
    output front_end_pkg::word_t head_pc0,
    output front_end_pkg::word_t head_pc1,
    output front_end_pkg::word_t head_instr0,
    output front_end_pkg::word_t head_instr1,
    input  logic [1:0]           pop_count,
    // back to fetch
    output logic [1:0]           credit_return
);
    import front_end_pkg::*;

    localparam int PW = $clog2(QUEUE_DEPTH);
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PW-1:0] ptr_t;

    word_t pc_mem [QUEUE_DEPTH];
    word_t instr_mem [QUEUE_DEPTH];

    ptr_t rd_ptr;
    ptr_t wr_ptr;
    ptr_t rd_ptr_1;
    ptr_t wr_idx1;
    logic [CW-1:0] count;
    logic [1:0] push_count;

    // pointer step with wrap, depth need not be a power of two
    function automatic ptr_t advance(ptr_t p, logic [1:0] n);
        logic [PW:0] sum;
        sum = {1'b0, p} + (PW + 1)'(n);
        if (sum >= (PW + 1)'(QUEUE_DEPTH))
            sum = sum - (PW + 1)'(QUEUE_DEPTH);
        return sum[PW-1:0];
    endfunction

    assign push_count = {1'b0, push_valid[1]} + {1'b0, push_valid[0]};
    assign rd_ptr_1 = advance(rd_ptr, 2'd1);
    // lane 1 lands right behind lane 0 when both are written
    assign wr_idx1 = push_valid[0] ? advance(wr_ptr, 2'd1) : wr_ptr;

    // two oldest entries
    assign head_valid = {(count >= CW'(2)), (count != '0)};
    assign head_pc0 = pc_mem[rd_ptr];
    assign head_instr0 = instr_mem[rd_ptr];
    assign head_pc1 = pc_mem[rd_ptr_1];
    assign head_instr1 = instr_mem[rd_ptr_1];

    always_ff @(posedge clk)
    begin
        if (push_valid[0])
        begin
            pc_mem[wr_ptr] <= push_pc0;
            instr_mem[wr_ptr] <= push_instr0;
        end
        if (push_valid[1])
        begin
            pc_mem[wr_idx1] <= push_pc1;
            instr_mem[wr_idx1] <= push_instr1;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            credit_return <= 2'd0;
        end
        else if (flush)
        begin
            // dropped entries give no credits back
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            credit_return <= 2'd0;
        end
        else
        begin
            rd_ptr <= advance(rd_ptr, pop_count);
            wr_ptr <= advance(wr_ptr, push_count);
            count <= count + CW'(push_count) - CW'(pop_count);
            credit_return <= pop_count;
        end
    end

endmodule

//--- logic/predecoder.sv
module predecoder (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         redirect,
    // queue heads
    input  logic [1:0]                   head_valid,
    input  front_end_pkg::word_t         head_pc0,
    input  front_end_pkg::word_t         head_pc1,
    input  front_end_pkg::word_t         head_instr0,
    input  front_end_pkg::word_t         head_instr1,
    output logic [1:0]                   pop_count,
    // jump redirect to fetch and queue
    output logic                         jump_redirect,
    output front_end_pkg::word_t         jump_target,
    // issue side
    output logic [1:0]                   issue_valid,
    output front_end_pkg::word_t         issue_pc0,
    output front_end_pkg::word_t         issue_pc1,
    output front_end_pkg::word_t         issue_instr0,
    output front_end_pkg::word_t         issue_instr1,
    output front_end_pkg::instr_class_t  issue_class0,
    output front_end_pkg::instr_class_t  issue_class1,
    input  logic                         issue_ready
);
    import front_end_pkg::*;

    instr_class_t cls0;
    instr_class_t cls1;
    logic jump0;
    logic jump1;
    logic take;
    logic [1:0] take_valid;

    assign cls0 = classify(head_instr0);
    assign cls1 = classify(head_instr1);
    assign jump0 = head_valid[0] && (cls0 == cls_jump);
    assign jump1 = head_valid[1] && (cls1 == cls_jump);

    // output register empty or being accepted, nothing while commit redirects
    assign take = !redirect && ((issue_valid == 2'b00) || issue_ready);

    always_comb
    begin
        take_valid = 2'b00;
        jump_redirect = 1'b0;
        // scoped call, the port of the same name hides the package function
        jump_target = front_end_pkg::jump_target(head_pc0, head_instr0);
        if (take)
        begin
            if (jump0)
            begin
                // younger lane is on the wrong path
                take_valid = 2'b01;
                jump_redirect = 1'b1;
            end
            else if (jump1)
            begin
                take_valid = 2'b11;
                jump_redirect = 1'b1;
                jump_target = front_end_pkg::jump_target(head_pc1, head_instr1);
            end
            else
            begin
                take_valid = head_valid;
            end
        end
        pop_count = {1'b0, take_valid[1]} + {1'b0, take_valid[0]};
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            issue_valid <= 2'b00;
        else if (redirect)
            issue_valid <= 2'b00;
        else if (take)
            issue_valid <= take_valid;
    end

    // payload, class travels with its instruction
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            issue_pc0 <= head_pc0;
            issue_pc1 <= head_pc1;
            issue_instr0 <= head_instr0;
            issue_instr1 <= head_instr1;
            issue_class0 <= cls0;
            issue_class1 <= cls1;
        end
    end

endmodule

//--- logic/front_end.sv
module front_end #(
    parameter int QUEUE_DEPTH = 8,
    parameter front_end_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                         clk,
    input  logic                         reset,
    // commit redirect
    input  logic                         redirect,
    input  front_end_pkg::word_t         redirect_pc,
    // instruction bus
    output logic                         ibus_req,
    output front_end_pkg::word_t         ibus_addr,
    input  logic                         ibus_resp,
    input  logic [63:0]                  ibus_data,
    // issue
    output logic [1:0]                   issue_valid,
    output front_end_pkg::word_t         issue_pc0,
    output front_end_pkg::word_t         issue_pc1,
    output front_end_pkg::word_t         issue_instr0,
    output front_end_pkg::word_t         issue_instr1,
    output front_end_pkg::instr_class_t  issue_class0,
    output front_end_pkg::instr_class_t  issue_class1,
    input  logic                         issue_ready
);
    import front_end_pkg::*;

    logic [1:0] push_valid;
    word_t push_pc0;
    word_t push_pc1;
    word_t push_instr0;
    word_t push_instr1;
    logic [1:0] credit_return;
    logic [1:0] head_valid;
    word_t head_pc0;
    word_t head_pc1;
    word_t head_instr0;
    word_t head_instr1;
    logic [1:0] pop_count;
    logic jump_redirect;
    word_t jump_target;
    logic flush;

    // either redirect empties the queue
    assign flush = redirect | jump_redirect;

    fetch_unit #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .RESET_PC(RESET_PC)
    ) fetch_unit_i (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .jump_redirect(jump_redirect),
        .jump_target(jump_target),
        .ibus_req(ibus_req),
        .ibus_addr(ibus_addr),
        .ibus_resp(ibus_resp),
        .ibus_data(ibus_data),
        .push_valid(push_valid),
        .push_pc0(push_pc0),
        .push_pc1(push_pc1),
        .push_instr0(push_instr0),
        .push_instr1(push_instr1),
        .credit_return(credit_return)
    );

    instr_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) instr_queue_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .push_valid(push_valid),
        .push_pc0(push_pc0),
        .push_pc1(push_pc1),
        .push_instr0(push_instr0),
        .push_instr1(push_instr1),
        .head_valid(head_valid),
        .head_pc0(head_pc0),
        .head_pc1(head_pc1),
        .head_instr0(head_instr0),
        .head_instr1(head_instr1),
        .pop_count(pop_count),
        .credit_return(credit_return)
    );

    predecoder predecoder_i (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .head_valid(head_valid),
        .head_pc0(head_pc0),
        .head_pc1(head_pc1),
        .head_instr0(head_instr0),
        .head_instr1(head_instr1),
        .pop_count(pop_count),
        .jump_redirect(jump_redirect),
        .jump_target(jump_target),
        .issue_valid(issue_valid),
        .issue_pc0(issue_pc0),
        .issue_pc1(issue_pc1),
        .issue_instr0(issue_instr0),
        .issue_instr1(issue_instr1),
        .issue_class0(issue_class0),
        .issue_class1(issue_class1),
        .issue_ready(issue_ready)
    );

endmodule

//--- bench/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // held over the first three rising edges
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- bench/imem_model.sv
module imem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ibus_req,
    input  front_end_pkg::word_t ibus_addr,
    input  logic [3:0]           latency,
    output logic                 ibus_resp,
    output logic [63:0]          ibus_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import front_end_pkg::*;

    word_t addr_q;
    logic busy;
    logic [3:0] wait_left;

    // memory contents, a pure function of the word address
    function automatic word_t word_at(word_t addr);
        word_t w;
        logic [25:0] here;
        here = addr[27:2];
        w = {6'b001001, here ^ {22'd0, addr[31:28]}};
        if (addr[23:16] == 8'h10)
        begin
            // one of each class, looping over a 32 byte block
            case (addr[4:2])
                3'd0: w = {6'b000000, addr[20:6], 5'd0, 6'b100001};
                3'd1: w = {6'b000000, addr[20:6], 5'd0, 6'b001000};
                3'd2: w = {6'b000100, here};
                3'd3: w = {6'b100011, here};
                3'd4: w = {6'b101011, here};
                3'd5: w = {6'b001101, here};
                3'd6: w = {6'b000101, here};
                default: w = {6'b000010, addr[27:5], 3'b000};
            endcase
        end
        else if (addr[23:12] == 12'h200)
        begin
            // j to +0x100, then jal at +0x104 to +0x200
            if (addr[11:0] == 12'h000)
                w = {6'b000010, here + 26'h40};
            else if (addr[11:0] == 12'h104)
                w = {6'b000011, here + 26'h3f};
        end
        return w;
    endfunction

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            addr_q <= '0;
            wait_left <= '0;
            ibus_resp <= 1'b0;
            ibus_data <= '0;
        end
        else
        begin
            ibus_resp <= 1'b0;
            if (busy)
            begin
                if (wait_left == 4'd0)
                begin
                    ibus_resp <= 1'b1;
                    ibus_data <= {word_at(addr_q + 32'd4), word_at(addr_q)};
                    busy <= 1'b0;
                end
                else
                    wait_left <= wait_left - 4'd1;
            end
            else if (ibus_req)
            begin
                busy <= 1'b1;
                addr_q <= ibus_addr;
                wait_left <= latency;
            end
        end
    end

endmodule

//--- bench/front_end_tb.sv
module front_end_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import front_end_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam word_t RESET_PC = 32'hbfc00000;
    localparam word_t CLASS_BASE = 32'hbf100000;
    localparam word_t JUMP_BASE = 32'hbf200000;
    localparam word_t ODD_PC = 32'hbf300004;
    localparam word_t RANDOM_BASE = 32'hbf400000;
    localparam int N_SEQ = 24;
    localparam int N_CLASS = 16;
    localparam int N_JUMP = 6;
    localparam int N_ODD = 8;
    localparam int N_RANDOM = 400;
    localparam int MAX_LATENCY = 8;
    localparam int TOTAL_ISSUES = N_SEQ + N_CLASS + N_JUMP + N_ODD + N_RANDOM;
    localparam int CYCLE_LIMIT = TOTAL_ISSUES * (MAX_LATENCY + 4) + 200;

    logic clk;
    logic reset;
    logic redirect;
    word_t redirect_pc;
    logic ibus_req;
    word_t ibus_addr;
    logic ibus_resp;
    logic [63:0] ibus_data;
    logic [1:0] issue_valid;
    word_t issue_pc0;
    word_t issue_pc1;
    word_t issue_instr0;
    word_t issue_instr1;
    instr_class_t issue_class0;
    instr_class_t issue_class1;
    logic issue_ready;
    logic [3:0] latency;

    // scoreboard and run state
    word_t exp_pc;
    logic [31:0] lfsr;
    logic [6:0] seen_class;
    logic [1:0] first_lanes;
    logic after_redirect;
    logic req_seen;
    logic random_mode;
    logic [3:0] latency_fixed;
    int issued;
    int jumps_taken;
    int errors;
    int failed_tests;
    int cycles;

    clock_gen clock_gen_i (
        .clk(clk),
        .reset(reset)
    );

    imem_model imem_i (
        .clk(clk),
        .reset(reset),
        .ibus_req(ibus_req),
        .ibus_addr(ibus_addr),
        .latency(latency),
        .ibus_resp(ibus_resp),
        .ibus_data(ibus_data)
    );

    front_end #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .RESET_PC(RESET_PC)
    ) front_end_i (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .ibus_req(ibus_req),
        .ibus_addr(ibus_addr),
        .ibus_resp(ibus_resp),
        .ibus_data(ibus_data),
        .issue_valid(issue_valid),
        .issue_pc0(issue_pc0),
        .issue_pc1(issue_pc1),
        .issue_instr0(issue_instr0),
        .issue_instr1(issue_instr1),
        .issue_class0(issue_class0),
        .issue_class1(issue_class1),
        .issue_ready(issue_ready)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // class by major opcode, funct only for special
    function automatic instr_class_t expected_class(word_t instr);
        instr_class_t c;
        casez (instr[31:26])
            6'b000000: c = (instr[5:0] == 6'b001000) ? cls_jump_reg : cls_alu_r;
            6'b00001?: c = cls_jump;
            6'b0001??: c = cls_branch;
            6'b100???: c = cls_load;
            6'b101???: c = cls_store;
            default: c = cls_alu_i;
        endcase
        return c;
    endfunction

    function automatic word_t jump_dest(word_t pc, word_t instr);
        word_t next_pc;
        next_pc = pc + 32'd4;
        return {next_pc[31:28], instr[25:0], 2'b00};
    endfunction

    task automatic report_failure(string what);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, what);
    endtask

    task automatic compare_word(string name, word_t got, word_t want);
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic compare_class(string name, instr_class_t got, instr_class_t want);
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t ns %s got %s expected %s", $time, name, got.name(),
                     want.name());
        end
    endtask

    task automatic compare_valid(string name, logic [1:0] got, logic [1:0] want);
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // one accepted instruction against the expected stream
    task automatic check_lane(int lane, word_t pc, word_t instr, instr_class_t cls);
        word_t want;
        instr_class_t want_class;
        want = imem_i.word_at(exp_pc);
        want_class = expected_class(want);
        compare_word($sformatf("issue_pc%0d", lane), pc, exp_pc);
        compare_word($sformatf("issue_instr%0d", lane), instr, want);
        compare_class($sformatf("issue_class%0d", lane), cls, want_class);
        seen_class[cls] = 1'b1;
        if (cls == cls_jump)
            jumps_taken++;
        if (want_class == cls_jump)
            exp_pc = jump_dest(exp_pc, want);
        else
            exp_pc = exp_pc + 32'd4;
        issued++;
    endtask

    // mid-cycle, outputs are settled
    task automatic observe();
        if (!reset)
        begin
            if (issue_valid == 2'b10)
                report_failure("lane 1 issued without lane 0");
            if (after_redirect && issue_valid != 2'b00)
            begin
                first_lanes = issue_valid;
                after_redirect = 1'b0;
            end
            if (issue_ready && issue_valid[0])
                check_lane(0, issue_pc0, issue_instr0, issue_class0);
            if (issue_ready && issue_valid[1])
                check_lane(1, issue_pc1, issue_instr1, issue_class1);
            if (redirect)
            begin
                exp_pc = redirect_pc;
                after_redirect = 1'b1;
            end
            req_seen = ibus_req;
        end
    endtask

    task automatic cycle();
        logic [31:0] bits;
        @(negedge clk);
        observe();
        @(posedge clk);
        #1;
        if (random_mode)
        begin
            // mostly stalled so the queue runs full and credits run out
            take_bits(3, bits);
            issue_ready = (bits[2:0] == 3'b000);
            take_bits(3, bits);
            latency = {1'b0, bits[2:0]};
        end
        else
        begin
            issue_ready = 1'b1;
            latency = latency_fixed;
        end
    endtask

    task automatic wait_issued(int n);
        int target;
        target = issued + n;
        while (issued < target)
            cycle();
    endtask

    task automatic commit_redirect(word_t pc);
        first_lanes = 2'b00;
        redirect = 1'b1;
        redirect_pc = pc;
        cycle();
        redirect = 1'b0;
    endtask

    task automatic finish_test(string name, int start_errors, int start_issued);
        $display("test %s: %0d issued, %0d errors", name, issued - start_issued,
                 errors - start_errors);
        if (errors != start_errors)
            failed_tests++;
    endtask

    task automatic test_sequential();
        int start_errors;
        int start_issued;
        start_errors = errors;
        start_issued = issued;
        @(negedge clk);
        if (ibus_req !== 1'b1)
            report_failure("no instruction request in the first cycle after reset");
        compare_word("ibus_addr", ibus_addr, RESET_PC & ~32'd4);
        compare_valid("issue_valid", issue_valid, 2'b00);
        if (front_end_i.jump_redirect !== 1'b0)
            report_failure("jump redirect raised straight after reset");
        @(posedge clk);
        #1;
        wait_issued(N_SEQ);
        finish_test("sequential", start_errors, start_issued);
    endtask

    task automatic test_classes();
        int start_errors;
        int start_issued;
        start_errors = errors;
        start_issued = issued;
        commit_redirect(CLASS_BASE);
        seen_class = '0;
        wait_issued(N_CLASS);
        if (seen_class != 7'h7f)
            report_failure($sformatf("classes issued %b, not all seven", seen_class));
        finish_test("classes", start_errors, start_issued);
    endtask

    task automatic test_jumps();
        int start_errors;
        int start_issued;
        int start_jumps;
        start_errors = errors;
        start_issued = issued;
        commit_redirect(JUMP_BASE);
        start_jumps = jumps_taken;
        wait_issued(N_JUMP);
        if (jumps_taken - start_jumps != 2)
            report_failure("j and jal were not both issued and followed");
        finish_test("jumps", start_errors, start_issued);
    endtask

    task automatic test_redirect_outstanding();
        int start_errors;
        int start_issued;
        start_errors = errors;
        start_issued = issued;
        latency_fixed = 4'd8;
        cycle();
        // catch a fresh request, then redirect while it is in flight
        do
            cycle();
        while (!req_seen);
        cycle();
        commit_redirect(ODD_PC);
        latency_fixed = 4'd1;
        wait_issued(N_ODD);
        compare_valid("issue_valid", first_lanes, 2'b01);
        finish_test("redirect", start_errors, start_issued);
    endtask

    task automatic test_random();
        int start_errors;
        int start_issued;
        start_errors = errors;
        start_issued = issued;
        random_mode = 1'b1;
        commit_redirect(RANDOM_BASE);
        wait_issued(N_RANDOM);
        random_mode = 1'b0;
        finish_test("random", start_errors, start_issued);
    endtask

    // cycle counter that ends a stuck run
    initial
    begin
        @(negedge reset);
        while (cycles < CYCLE_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d issued", cycles, issued);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        redirect = 1'b0;
        redirect_pc = '0;
        issue_ready = 1'b1;
        latency = 4'd2;
        latency_fixed = 4'd2;
        random_mode = 1'b0;
        lfsr = 32'h7d68;
        exp_pc = RESET_PC;
        seen_class = '0;
        first_lanes = 2'b00;
        after_redirect = 1'b0;
        req_seen = 1'b0;
        issued = 0;
        jumps_taken = 0;
        errors = 0;
        failed_tests = 0;
        cycles = 0;
        @(negedge reset);
        test_sequential();
        test_classes();
        test_jumps();
        test_redirect_outstanding();
        test_random();
        $display("tests 5, failed %0d, errors %0d, issued %0d", failed_tests, errors, issued);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tb.f
logic/front_end_pkg.sv
logic/fetch_unit.sv
logic/instr_queue.sv
logic/predecoder.sv
logic/front_end.sv
bench/clock_gen.sv
bench/imem_model.sv
bench/front_end_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f tb.f --top-module front_end_tb -o front_end_sim
./obj_dir/front_end_sim > sim.log
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished"
